/* Makefile */
# Verilator build and run for the analog core

VERILATOR ?= verilator
TOP       ?= tb_rp_analog
RTL_TOP   ?= rp_analog_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_clk_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 100 ns adc_clk
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // five full periods low, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    #(5 * 100);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* bench/tb_rp_analog.sv */
// Analog core testbench
`timescale 1ns/1ns
`default_nettype none

module tb_rp_analog import rp_pkg::*; ();

  logic               adc_clk;
  logic               rst_n;
  logic               pll_locked;
  adc_raw_t           adc_raw;
  adc_pair_t          asg_dat;
  adc_pair_t          pid_dat;
  logic               trig_ext;
  logic               scope_trig;
  logic               asg_trig;
  logic [DAISY_W-1:0] daisy_rx_dat;
  logic               daisy_rx_rdy;
  logic               cfg_we;
  cfg_addr_e          cfg_addr;
  logic [2:0]         cfg_wdata;
  // dut outputs
  logic               run;
  logic [2:0]         cfg_rdata;
  adc_pair_t          adc_dat;
  dac_pair_t          dac_dat;
  logic               trig_ext_mask;
  logic               trig_out;
  logic [DAISY_W-1:0] daisy_tx_dat;
  logic               daisy_tx_dv;

  int unsigned checks;
  int unsigned errors;
  logic [31:0] rng;
  int          n_rand = 200;

  // generator / controller edge pairs, ch_b gets them swapped
  logic [13:0] edge_asg [9] = '{14'h1fff, 14'h2000, 14'h1fff, 14'h2000, 14'h1fff,
                                14'h2000, 14'h0000, 14'h0fa0, 14'h3000};
  logic [13:0] edge_pid [9] = '{14'h1fff, 14'h2000, 14'h2000, 14'h1fff, 14'h0001,
                                14'h3fff, 14'h0000, 14'h105f, 14'h3000};

  tb_clk_gen i_clk_gen (
    .clk_o   (adc_clk),
    .rst_n_o (rst_n)
  );

  rp_analog_top i_rp_analog_top (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n),
    .pll_locked_i   (pll_locked),
    .adc_raw_i      (adc_raw),
    .asg_dat_i      (asg_dat),
    .pid_dat_i      (pid_dat),
    .trig_ext_i     (trig_ext),
    .scope_trig_i   (scope_trig),
    .asg_trig_i     (asg_trig),
    .daisy_rx_dat_i (daisy_rx_dat),
    .daisy_rx_rdy_i (daisy_rx_rdy),
    .cfg_we_i       (cfg_we),
    .cfg_addr_i     (cfg_addr),
    .cfg_wdata_i    (cfg_wdata),
    .run_o          (run),
    .cfg_rdata_o    (cfg_rdata),
    .adc_dat_o      (adc_dat),
    .dac_dat_o      (dac_dat),
    .trig_ext_o     (trig_ext_mask),
    .trig_out_o     (trig_out),
    .daisy_tx_dat_o (daisy_tx_dat),
    .daisy_tx_dv_o  (daisy_tx_dv)
  );

  ////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // msb stays, rest inverted
  function automatic logic [13:0] flip_ref(input logic [13:0] w);
    return w ^ 14'h1fff;
  endfunction

  function automatic logic [13:0] sat_ref(input logic [13:0] a, input logic [13:0] b);
    int s;
    s = int'($signed(a)) + int'($signed(b));
    if (s > 8191) begin
      s = 8191;
    end else if (s < -8192) begin
      s = -8192;
    end
    return s[13:0];
  endfunction

  // top 14 of 16 raw bits
  function automatic adc_pair_t adc_expect(input adc_raw_t raw);
    adc_pair_t e;
    e.ch_a = flip_ref(raw.ch_a[15:2]);
    e.ch_b = flip_ref(raw.ch_b[15:2]);
    return e;
  endfunction

  function automatic adc_pair_t sat_expect(input adc_pair_t a, input adc_pair_t b);
    adc_pair_t e;
    e.ch_a = sat_ref(a.ch_a, b.ch_a);
    e.ch_b = sat_ref(a.ch_b, b.ch_b);
    return e;
  endfunction

  function automatic dac_pair_t dac_expect(input adc_pair_t s);
    dac_pair_t e;
    e.ch_a = flip_ref(s.ch_a);
    e.ch_b = flip_ref(s.ch_b);
    return e;
  endfunction

  ////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // checks sit right after the falling edge, drives follow them
  task automatic next_cycle();
    @(posedge adc_clk);
    @(negedge adc_clk);
  endtask

  task automatic load_random_inputs();
    rng = xorshift32(rng);
    adc_raw = rng;
    rng = xorshift32(rng);
    asg_dat = rng[27:0];
    rng = xorshift32(rng);
    pid_dat = rng[27:0];
  endtask

  // n counts rising edges, the first one samples the lock
  task automatic wait_for_run(output int n);
    n = 0;
    while (!run && n < RST_MAX + 20) begin
      next_cycle();
      n++;
    end
    assert (run) else begin
      errors++;
      $display("run_o did not rise within %0d cycles of pll lock", n);
    end
  endtask

  task automatic write_and_readback(input cfg_addr_e addr, input logic [2:0] data,
                                    input logic [2:0] exp);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    next_cycle();
    cfg_we = 1'b0;
    compare_value("cfg_rdata_o", 32'(cfg_rdata), 32'(exp));
  endtask

  ////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////

  task automatic reset_and_lock();
    int n;
    load_random_inputs();
    compare_value("run_o after reset", 32'(run), 0);
    compare_value("adc_dat_o after reset", 32'(adc_dat), 0);
    compare_value("dac_dat_o after reset", 32'(dac_dat), 0);
    pll_locked = 1'b1;
    wait_for_run(n);
    compare_value("edges from lock to run_o", 32'(n - 1), 32'(RST_MAX + 1));
    // outputs live before the lock goes away
    next_cycle();
    compare_value("adc_dat_o after release", 32'(adc_dat), 32'(adc_expect(adc_raw)));
    compare_value("dac_dat_o after release", 32'(dac_dat),
                  32'(dac_expect(sat_expect(asg_dat, pid_dat))));
    pll_locked = 1'b0;
    next_cycle();
    compare_value("run_o after lock loss", 32'(run), 0);
    next_cycle();
    compare_value("adc_dat_o after lock loss", 32'(adc_dat), 0);
    compare_value("dac_dat_o after lock loss", 32'(dac_dat), 0);
    pll_locked = 1'b1;
    wait_for_run(n);
    compare_value("edges from relock to run_o", 32'(n - 1), 32'(RST_MAX + 1));
  endtask

  task automatic adc_conversion();
    for (int i = 0; i < n_rand; i++) begin
      load_random_inputs();
      next_cycle();
      compare_value("adc_dat_o conversion", 32'(adc_dat), 32'(adc_expect(adc_raw)));
    end
  endtask

  // edge pairs first, then random
  task automatic dac_saturation();
    for (int i = 0; i < n_rand + 9; i++) begin
      if (i < 9) begin
        asg_dat.ch_a = edge_asg[i];
        pid_dat.ch_a = edge_pid[i];
        asg_dat.ch_b = edge_pid[i];
        pid_dat.ch_b = edge_asg[i];
      end else begin
        load_random_inputs();
      end
      next_cycle();
      compare_value("dac_dat_o sum", 32'(dac_dat),
                    32'(dac_expect(sat_expect(asg_dat, pid_dat))));
    end
  endtask

  task automatic config_loopback();
    adc_raw_t raw_prev;
    write_and_readback(REG_DAISY, 3'b101, 3'b101);
    write_and_readback(REG_DAISY, 3'b010, 3'b010);
    // REG_LOOP keeps two bits only
    write_and_readback(REG_LOOP, 3'b101, 3'b001);
    for (int i = 0; i < 20; i++) begin
      load_random_inputs();
      next_cycle();
      compare_value("adc loopback", 32'(adc_dat), 32'(sat_expect(asg_dat, pid_dat)));
    end
    write_and_readback(REG_LOOP, 3'b010, 3'b010);
    raw_prev = adc_raw;
    for (int i = 0; i < 20; i++) begin
      load_random_inputs();
      next_cycle();
      compare_value("adc_dat_o in dac loop", 32'(adc_dat), 32'(adc_expect(adc_raw)));
      // dac sees the registered adc word, one more cycle back
      if (i > 0) begin
        compare_value("dac loopback", 32'(dac_dat), 32'(dac_expect(adc_expect(raw_prev))));
      end
      raw_prev = adc_raw;
    end
    write_and_readback(REG_LOOP, 3'b000, 3'b000);
  endtask

  task automatic trigger_routing();
    logic               sync;
    logic               ext_exp;
    logic               out_exp;
    logic [DAISY_W-1:0] dat_exp;
    for (int m = 0; m < 8; m++) begin
      write_and_readback(REG_DAISY, 3'(m), 3'(m));
      for (int c = 0; c < 32; c++) begin
        rng = xorshift32(rng);
        trig_ext     = c[0];
        scope_trig   = c[1];
        asg_trig     = c[2];
        daisy_rx_rdy = c[3];
        // forced nonzero when selected
        daisy_rx_dat = c[4] ? (rng[15:0] | 16'h0001) : 16'h0000;
        next_cycle();
        sync    = m[0];
        // c[4] alone says whether any rx bit is set
        ext_exp = c[0] && !(sync && c[4]);
        out_exp = m[2] ? c[2] : c[1];
        dat_exp = sync ? {DAISY_W{out_exp}} : DAISY_IDLE;
        compare_value("trig_ext_o", 32'(trig_ext_mask), 32'(ext_exp));
        compare_value("trig_out_o", 32'(trig_out), 32'(out_exp));
        compare_value("daisy_tx_dat_o", 32'(daisy_tx_dat), 32'(dat_exp));
        compare_value("daisy_tx_dv_o", 32'(daisy_tx_dv), 32'(sync ? 1'b0 : c[3]));
      end
    end
    write_and_readback(REG_DAISY, 3'b000, 3'b000);
  endtask

  ////////////////////////////////////////////////////////////////////////
  // sequence and watchdog
  ////////////////////////////////////////////////////////////////////////

  initial begin
    pll_locked   = 1'b0;
    adc_raw      = '0;
    asg_dat      = '0;
    pid_dat      = '0;
    trig_ext     = 1'b0;
    scope_trig   = 1'b0;
    asg_trig     = 1'b0;
    daisy_rx_dat = '0;
    daisy_rx_rdy = 1'b0;
    cfg_we       = 1'b0;
    cfg_addr     = REG_LOOP;
    cfg_wdata    = 3'd0;
    checks       = 0;
    errors       = 0;
    rng          = 32'd90715;
    @(posedge rst_n);
    @(negedge adc_clk);
    reset_and_lock();
    adc_conversion();
    dac_saturation();
    config_loopback();
    trigger_routing();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // lock waits, two random sweeps, loopback runs, 8 daisy modes, then margin
  initial begin : watchdog
    int unsigned budget;
    budget = 20 + 3 * (RST_MAX + 20) + 2 * n_rand + 60 + 8 * 40 + 100;
    #(budget * 100);
    $display("watchdog expired after %0d cycles before the tests finished", budget);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
source/rp_pkg.sv
source/rp_hk_ctrl.sv
source/rp_adc_frontend.sv
source/rp_dac_backend.sv
source/rp_trig_route.sv
source/rp_analog_top.sv
bench/tb_clk_gen.sv
bench/tb_rp_analog.sv

/* source/rp_adc_frontend.sv */
// ADC front end
`timescale 1ns/1ns
`default_nettype none

module rp_adc_frontend import rp_pkg::*; (
  input  wire       adc_clk,
  input  wire       rst_n_i,
  input  wire       run_i,
  input  wire       loop_adc_i,
  input  adc_raw_t  adc_raw_i,
  input  adc_pair_t dac_sat_i,
  output adc_pair_t adc_dat_o
);

  // channel view of the pair structs, index 1 is ch_a
  logic [N_CH-1:0][ADC_PIN_W-1:0] raw_v;
  logic [N_CH-1:0][ADW-1:0]       conv_v;

  assign raw_v = adc_raw_i;

  // top ADW bits, neg slope to two's complement
  always_comb begin
    for (int i = 0; i < N_CH; i++) begin
      conv_v[i] = nslope_flip(raw_v[i][ADC_PIN_W-1 -: ADW]);
    end
  end

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      adc_dat_o <= '0;
    end else if (!run_i) begin
      // held in zero until the sequencer releases
      adc_dat_o <= '0;
    end else if (loop_adc_i) begin
      // digital loop, saturated dac sum in place of the adc
      adc_dat_o <= dac_sat_i;
    end else begin
      adc_dat_o <= conv_v;
    end
  end

  a_hold_zero: assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    !run_i |=> (adc_dat_o == '0)
  ) else $error("adc_dat_o nonzero after run_i low");

endmodule

`default_nettype wire

/* source/rp_analog_top.sv */
// Analog core top level
`timescale 1ns/1ns
`default_nettype none

module rp_analog_top import rp_pkg::*; (
  input  wire                 adc_clk,
  input  wire                 rst_n_i,
  input  wire                 pll_locked_i,
  // converters and stream sources
  input  adc_raw_t            adc_raw_i,
  input  adc_pair_t           asg_dat_i,
  input  adc_pair_t           pid_dat_i,
  // trigger and daisy
  input  wire                 trig_ext_i,
  input  wire                 scope_trig_i,
  input  wire                 asg_trig_i,
  input  wire  [DAISY_W-1:0]  daisy_rx_dat_i,
  input  wire                 daisy_rx_rdy_i,
  // register port
  input  wire                 cfg_we_i,
  input  cfg_addr_e           cfg_addr_i,
  input  wire  [2:0]          cfg_wdata_i,
  output logic                run_o,
  output logic [2:0]          cfg_rdata_o,
  output adc_pair_t           adc_dat_o,
  output dac_pair_t           dac_dat_o,
  output logic                trig_ext_o,
  output logic                trig_out_o,
  output logic [DAISY_W-1:0]  daisy_tx_dat_o,
  output logic                daisy_tx_dv_o
);

  //////////////////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////////////////

  cfg_t      cfg;
  // combinational saturated sum, feeds adc loopback
  adc_pair_t dac_sat;

  rp_hk_ctrl i_hk_ctrl (
    .adc_clk      (adc_clk),
    .rst_n_i      (rst_n_i),
    .pll_locked_i (pll_locked_i),
    .cfg_we_i     (cfg_we_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .run_o        (run_o),
    .cfg_o        (cfg),
    .cfg_rdata_o  (cfg_rdata_o)
  );

  //////////////////////////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////////////////////////

  // adc_dat_o also goes back into the dac for loopback
  rp_adc_frontend i_adc_frontend (
    .adc_clk    (adc_clk),
    .rst_n_i    (rst_n_i),
    .run_i      (run_o),
    .loop_adc_i (cfg.loop_adc),
    .adc_raw_i  (adc_raw_i),
    .dac_sat_i  (dac_sat),
    .adc_dat_o  (adc_dat_o)
  );

  rp_dac_backend i_dac_backend (
    .adc_clk    (adc_clk),
    .rst_n_i    (rst_n_i),
    .run_i      (run_o),
    .loop_dac_i (cfg.loop_dac),
    .asg_dat_i  (asg_dat_i),
    .pid_dat_i  (pid_dat_i),
    .adc_dat_i  (adc_dat_o),
    .dac_sat_o  (dac_sat),
    .dac_dat_o  (dac_dat_o)
  );

  rp_trig_route i_trig_route (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .run_i          (run_o),
    .daisy_mode_i   (cfg.daisy_mode),
    .trig_ext_i     (trig_ext_i),
    .scope_trig_i   (scope_trig_i),
    .asg_trig_i     (asg_trig_i),
    .daisy_rx_dat_i (daisy_rx_dat_i),
    .daisy_rx_rdy_i (daisy_rx_rdy_i),
    .trig_ext_o     (trig_ext_o),
    .trig_out_o     (trig_out_o),
    .daisy_tx_dat_o (daisy_tx_dat_o),
    .daisy_tx_dv_o  (daisy_tx_dv_o)
  );

endmodule

`default_nettype wire

/* source/rp_dac_backend.sv */
// DAC back end
`timescale 1ns/1ns
`default_nettype none

module rp_dac_backend import rp_pkg::*; (
  input  wire       adc_clk,
  input  wire       rst_n_i,
  input  wire       run_i,
  input  wire       loop_dac_i,
  input  adc_pair_t asg_dat_i,
  input  adc_pair_t pid_dat_i,
  input  adc_pair_t adc_dat_i,
  output adc_pair_t dac_sat_o,
  output dac_pair_t dac_dat_o
);

  // channel views, index 1 is ch_a
  logic [N_CH-1:0][DDW-1:0]   asg_v;
  logic [N_CH-1:0][DDW-1:0]   pid_v;
  logic [N_CH-1:0][ADW-1:0]   adc_v;
  logic [N_CH-1:0][SUM_W-1:0] sum_v;
  logic [N_CH-1:0][DDW-1:0]   sat_v;
  logic [N_CH-1:0][DDW-1:0]   out_v;

  assign asg_v = asg_dat_i;
  assign pid_v = pid_dat_i;
  assign adc_v = adc_dat_i;

  always_comb begin
    for (int i = 0; i < N_CH; i++) begin
      // sign extend both by one bit then add
      sum_v[i] = {asg_v[i][DDW-1], asg_v[i]} + {pid_v[i][DDW-1], pid_v[i]};
      // top two bits differ means overflow, clamp toward the sign
      if (sum_v[i][SUM_W-1] ^ sum_v[i][SUM_W-2]) begin
        sat_v[i] = {sum_v[i][SUM_W-1], {(DDW-1){~sum_v[i][SUM_W-1]}}};
      end else begin
        sat_v[i] = sum_v[i][DDW-1:0];
      end
      // loopback takes top DDW bits of the adc sample
      out_v[i] = loop_dac_i ? nslope_flip(adc_v[i][ADW-1 -: DDW]) : nslope_flip(sat_v[i]);
    end
  end

  assign dac_sat_o = sat_v;

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dac_dat_o <= '0;
    end else if (!run_i) begin
      dac_dat_o <= '0;
    end else begin
      dac_dat_o <= out_v;
    end
  end

  // no clamping while the sum fits in DDW bits
  a_sat_in_range: assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    (sum_v[1][SUM_W-1] == sum_v[1][SUM_W-2]) && (sum_v[0][SUM_W-1] == sum_v[0][SUM_W-2])
    |-> (dac_sat_o == {sum_v[1][DDW-1:0], sum_v[0][DDW-1:0]})
  ) else $error("saturated word differs from in-range sum");

endmodule

`default_nettype wire

/* source/rp_hk_ctrl.sv */
// Reset sequencer and configuration registers
`timescale 1ns/1ns
`default_nettype none

module rp_hk_ctrl import rp_pkg::*; (
  input  wire        adc_clk,
  input  wire        rst_n_i,
  input  wire        pll_locked_i,
  input  wire        cfg_we_i,
  input  cfg_addr_e  cfg_addr_i,
  input  wire  [2:0] cfg_wdata_i,
  output logic       run_o,
  output cfg_t       cfg_o,
  output logic [2:0] cfg_rdata_o
);

  //////////////////////////////////////////////////////////////////////
  // reset sequencer
  //////////////////////////////////////////////////////////////////////

  seq_state_e            state;
  logic [HOLD_CNT_W-1:0] hold_cnt;

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state    <= SEQ_WAIT_LOCK;
      hold_cnt <= '0;
      run_o    <= 1'b0;
    end else begin
      // one edge behind the state, drops with lock at once
      run_o <= pll_locked_i && (state == SEQ_RUN);
      if (!pll_locked_i) begin
        // lock lost, start over
        state    <= SEQ_WAIT_LOCK;
        hold_cnt <= '0;
      end else begin
        case (state)
          SEQ_WAIT_LOCK: begin
            state    <= SEQ_HOLD;
            hold_cnt <= '0;
          end
          SEQ_HOLD: begin
            // RST_MAX edges in hold, counter wraps back to 0
            if (hold_cnt == HOLD_CNT_W'(RST_MAX - 1)) begin
              state <= SEQ_RUN;
            end
            hold_cnt <= hold_cnt + 1'b1;
          end
          SEQ_RUN: begin
            hold_cnt <= '0;
          end
          default: begin
            state <= SEQ_WAIT_LOCK;
          end
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // configuration registers
  //////////////////////////////////////////////////////////////////////

  // only rst_n_i clears config, lock loss keeps it
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_o <= '0;
    end else if (cfg_we_i) begin
      case (cfg_addr_i)
        REG_LOOP: begin
          cfg_o.loop_adc <= cfg_wdata_i[0];
          cfg_o.loop_dac <= cfg_wdata_i[1];
        end
        REG_DAISY: begin
          cfg_o.daisy_mode <= cfg_wdata_i;
        end
        default: begin
          cfg_o <= cfg_o;
        end
      endcase
    end
  end

  // readback follows address, no wait
  always_comb begin
    case (cfg_addr_i)
      REG_LOOP:  cfg_rdata_o = {1'b0, cfg_o.loop_dac, cfg_o.loop_adc};
      REG_DAISY: cfg_rdata_o = cfg_o.daisy_mode;
      default:   cfg_rdata_o = 3'd0;
    endcase
  end

  // datapath must be held the cycle after lock goes away
  a_run_after_unlock: assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    !pll_locked_i |=> !run_o
  ) else $error("run_o high after pll lock loss");

endmodule

`default_nettype wire

/* source/rp_pkg.sv */
// Analog core shared definitions
`default_nettype none

package rp_pkg;

  //////////////////////////////////////////////////////////////////////
  // converter widths
  //////////////////////////////////////////////////////////////////////

  // raw pin bus, low bits unused on 14-bit parts
  localparam int ADC_PIN_W = 16;
  localparam int ADW       = 14;
  localparam int DDW       = 14;
  // one guard bit for asg + pid
  localparam int SUM_W     = DDW + 1;
  localparam int N_CH      = 2;

  // datapath hold after pll lock
  localparam int RST_MAX    = 64;
  localparam int HOLD_CNT_W = $clog2(RST_MAX);

  // daisy parallel side
  localparam int                 DAISY_W    = 16;
  localparam logic [DAISY_W-1:0] DAISY_IDLE = 16'h1234;

  //////////////////////////////////////////////////////////////////////
  // channel pairs, ch_a sits in the upper half
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [ADC_PIN_W-1:0] ch_a;
    logic [ADC_PIN_W-1:0] ch_b;
  } adc_raw_t;

  typedef struct packed {
    logic signed [ADW-1:0] ch_a;
    logic signed [ADW-1:0] ch_b;
  } adc_pair_t;

  // offset binary, negative slope
  typedef struct packed {
    logic [DDW-1:0] ch_a;
    logic [DDW-1:0] ch_b;
  } dac_pair_t;

  // daisy_mode: [0] sync, [1] reserved, [2] trigger out from generator
  typedef struct packed {
    logic       loop_adc;
    logic       loop_dac;
    logic [2:0] daisy_mode;
  } cfg_t;

  typedef enum logic [1:0] {
    REG_LOOP  = 2'd0,
    REG_DAISY = 2'd1
  } cfg_addr_e;

  typedef enum logic [1:0] {
    SEQ_WAIT_LOCK = 2'd0,
    SEQ_HOLD      = 2'd1,
    SEQ_RUN       = 2'd2
  } seq_state_e;

  // neg-slope offset binary <-> two's complement, same op both ways
  function automatic logic [ADW-1:0] nslope_flip(input logic [ADW-1:0] d);
    return {d[ADW-1], ~d[ADW-2:0]};
  endfunction

endpackage

`default_nettype wire

/* source/rp_trig_route.sv */
// Trigger and daisy routing
`timescale 1ns/1ns
`default_nettype none

module rp_trig_route import rp_pkg::*; (
  input  wire                adc_clk,
  input  wire                rst_n_i,
  input  wire                run_i,
  // [1] reserved
  input  wire  [2:0]         daisy_mode_i,
  input  wire                trig_ext_i,
  input  wire                scope_trig_i,
  input  wire                asg_trig_i,
  input  wire  [DAISY_W-1:0] daisy_rx_dat_i,
  input  wire                daisy_rx_rdy_i,
  output logic               trig_ext_o,
  output logic               trig_out_o,
  output logic [DAISY_W-1:0] daisy_tx_dat_o,
  output logic               daisy_tx_dv_o
);

  logic sync_mode;
  logic trig_sel;

  assign sync_mode = daisy_mode_i[0];
  // generator or scope drives the outgoing trigger
  assign trig_sel  = daisy_mode_i[2] ? asg_trig_i : scope_trig_i;

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      trig_ext_o     <= 1'b0;
      trig_out_o     <= 1'b0;
      daisy_tx_dat_o <= '0;
      daisy_tx_dv_o  <= 1'b0;
    end else if (!run_i) begin
      // held quiet until the sequencer releases
      trig_ext_o     <= 1'b0;
      trig_out_o     <= 1'b0;
      daisy_tx_dat_o <= '0;
      daisy_tx_dv_o  <= 1'b0;
    end else begin
      // in sync mode, incoming daisy trigger blocks the external one
      trig_ext_o     <= trig_ext_i & ~(sync_mode & (|daisy_rx_dat_i));
      trig_out_o     <= trig_sel;
      daisy_tx_dat_o <= sync_mode ? {DAISY_W{trig_sel}} : DAISY_IDLE;
      daisy_tx_dv_o  <= sync_mode ? 1'b0 : daisy_rx_rdy_i;
    end
  end

  a_no_dv_in_sync: assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    sync_mode |=> !daisy_tx_dv_o
  ) else $error("daisy_tx_dv_o high in sync mode");

endmodule

`default_nettype wire
